// File: project.f
+incdir+design
design/ciPkg.sv
design/ciIssueIf.sv
design/ciDecode.sv
design/ciExecute.sv
design/profileCounters.sv
design/ciResult.sv
design/customInstrUnit.sv
verif/customInstrUnit_properties.sv
verif/customInstrUnitTb.sv

// File: verif/customInstrUnitTb.sv
`timescale 1ns/10ps
`include "customInstr_settings.svh"

module customInstrUnitTb;

  localparam int NumInstr   = 400;
  localparam int CycleLimit = 5 + NumInstr * 4 + 20;
  localparam int Latency    = 3; // Start to done

  logic          systemClock;
  logic          rstN;
  logic          ciStart;
  ciPkg::ciIdT   ciN;
  ciPkg::ciDataT ciDataA;
  ciPkg::ciDataT ciDataB;
  logic          stall;
  logic          busIdle;
  logic          ciDone;
  ciPkg::ciDataT ciResult;

  logic [31:0]   lfsrState = 32'hbe76_5d94;
  int            cycleCount = 0;
  int            watchdogCycles = 0;
  int            issued = 0;
  int            dueQ[$];
  ciPkg::ciDataT valueQ[$];

  // Profiler model
  ciPkg::ciDataT                modelCnt [`PROFILE_COUNTERS];
  logic [`PROFILE_COUNTERS-1:0] modelEn;
  logic                         pendingProfile;
  logic [5:0]                   pendingCtrl;

  customInstrUnit UUT (
    .systemClock (systemClock),
    .rstN        (rstN),
    .ciStart     (ciStart),
    .ciN         (ciN),
    .ciDataA     (ciDataA),
    .ciDataB     (ciDataB),
    .stall       (stall),
    .busIdle     (busIdle),
    .ciDone      (ciDone),
    .ciResult    (ciResult)
  );

  bind customInstrUnit customInstrUnitProperties props (
    .systemClock (systemClock),
    .rstN        (rstN),
    .ciStart     (ciStart),
    .ciDone      (ciDone),
    .ciResult    (ciResult)
  );

  initial begin
    systemClock = 1'b0;
    forever #50 systemClock = ~systemClock;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrStep(lfsrState);
      value     = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  function automatic ciPkg::ciDataT swapModel(input ciPkg::ciDataT a, input logic halfwords);
    ciPkg::ciDataT out;
    for (int i = 0; i < 4; i++) begin
      if (halfwords)
        out[8*i +: 8] = a[8*(i ^ 1) +: 8];
      else
        out[8*i +: 8] = a[8*(3 - i) +: 8];
    end
    return out;
  endfunction

  function automatic ciPkg::ciDataT grayModel(input ciPkg::ciDataT a);
    int r;
    int g;
    int b;
    r = a[15:11];
    g = a[10:5];
    b = a[4:0];
    r = (r << 3) | (r >> 2);
    g = (g << 2) | (g >> 4);
    b = (b << 3) | (b >> 2);
    return ciPkg::ciDataT'((r * `GRAY_WEIGHT_RED + g * `GRAY_WEIGHT_GREEN +
                            b * `GRAY_WEIGHT_BLUE) >> 8);
  endfunction

  // One DUT edge of the counters where clear beats count
  task automatic stepModel(input logic stallIn, input logic idleIn);
    logic hit;
    for (int i = 0; i < `PROFILE_COUNTERS; i++) begin
      hit = (i == 0) || (i == 1 && stallIn) || (i == 2 && idleIn);
      if (pendingProfile && pendingCtrl[`PROFILE_COUNTERS + i])
        modelCnt[i] = '0;
      else if (modelEn[i] && hit)
        modelCnt[i] = modelCnt[i] + 1;
    end
    if (pendingProfile)
      modelEn = pendingCtrl[`PROFILE_COUNTERS-1:0];
    pendingProfile = 1'b0;
  endtask

  task automatic stopRun();
    $display("sim failed");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic checkDone(input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error at %0t: ciDone was %b, expected %b", $time, actual, expected);
      stopRun();
    end
  endtask

  task automatic checkResult(input ciPkg::ciDataT expected, input ciPkg::ciDataT actual);
    if (actual !== expected) begin
      $display("Error at %0t: ciResult was %h, expected %h", $time, actual, expected);
      stopRun();
    end
  endtask

  task automatic runCycle(input logic allowIssue);
    logic                         expDone;
    ciPkg::ciDataT                expValue;
    logic                         start;
    logic [1:0]                   kind;
    ciPkg::ciIdT                  id;
    ciPkg::ciDataT                dataA;
    ciPkg::ciDataT                dataB;
    logic [`PROFILE_COUNTERS-1:0] enBits;
    logic [`PROFILE_COUNTERS-1:0] clrBits;
    @(posedge systemClock);
    #1;
    cycleCount++;
    expDone  = 1'b0;
    expValue = '0;
    if (dueQ.size() != 0 && dueQ[0] == cycleCount) begin
      expDone  = 1'b1;
      expValue = valueQ.pop_front();
      void'(dueQ.pop_front());
    end
    checkDone(expDone, ciDone);
    checkResult(expValue, ciResult);

    start = allowIssue && (takeBits(2) != 0); // About three starts in four cycles
    kind  = 2'(takeBits(2));
    id    = ciPkg::ciIdT'(takeBits(8));
    dataA = takeBits(32);
    dataB = takeBits(32);
    case (kind)
      2'd0: id = `CI_SWAP_ID;
      2'd1: id = `CI_GRAY_ID;
      2'd2: begin
        id = `CI_PROFILE_ID;
        for (int i = 0; i < `PROFILE_COUNTERS; i++) begin
          enBits[i]  = takeBits(2) != 0; // Mostly enabled
          clrBits[i] = takeBits(3) == 0;
        end
        dataB[5:0] = {clrBits, enBits};
      end
      default: begin
        if (id == `CI_SWAP_ID || id == `CI_GRAY_ID || id == `CI_PROFILE_ID)
          id = id ^ 8'h80;
      end
    endcase
    ciStart = start;
    ciN     = id;
    ciDataA = dataA;
    ciDataB = dataB;
    stall   = 1'(takeBits(1));
    busIdle = 1'(takeBits(1));

    stepModel(stall, busIdle); // Next edge sees these inputs
    if (start) begin
      issued++;
      case (kind)
        2'd0: begin
          dueQ.push_back(cycleCount + Latency);
          valueQ.push_back(swapModel(dataA, dataB[0]));
        end
        2'd1: begin
          dueQ.push_back(cycleCount + Latency);
          valueQ.push_back(grayModel(dataA));
        end
        2'd2: begin
          dueQ.push_back(cycleCount + Latency);
          if (dataA[1:0] < `PROFILE_COUNTERS)
            valueQ.push_back(modelCnt[dataA[1:0]]);
          else
            valueQ.push_back('0);
          pendingProfile = 1'b1;
          pendingCtrl    = dataB[5:0];
        end
        default: ; // Unknown number gets no done
      endcase
    end
  endtask

  always @(posedge systemClock) begin
    watchdogCycles++;
    if (watchdogCycles >= CycleLimit) begin
      $display("timeout: instructions did not complete");
      stopRun();
    end
  end

  initial begin
    rstN           = 1'b1;
    ciStart        = 1'b0;
    ciN            = '0;
    ciDataA        = '0;
    ciDataB        = '0;
    stall          = 1'b0;
    busIdle        = 1'b0;
    modelEn        = '0;
    pendingProfile = 1'b0;
    pendingCtrl    = '0;
    for (int i = 0; i < `PROFILE_COUNTERS; i++)
      modelCnt[i] = '0;
    #1 rstN = 1'b0; // Clean falling edge for the async reset
    repeat (5) @(posedge systemClock);
    #1;
    checkDone(1'b0, ciDone);
    checkResult('0, ciResult);
    rstN = 1'b1;
    while (issued < NumInstr)
      runCycle(1'b1);
    while (dueQ.size() != 0)
      runCycle(1'b0);
    repeat (4) runCycle(1'b0); // No stray done afterwards
    $display("sim passed");
    $finish;
  end

endmodule

// File: verif/customInstrUnit_properties.sv
`timescale 1ns/10ps

module customInstrUnitProperties (
  input logic          systemClock,
  input logic          rstN,
  input logic          ciStart,
  input logic          ciDone,
  input ciPkg::ciDataT ciResult
);

  // Back-to-back dones need back-to-back starts
  doneRun: assert property (@(posedge systemClock) disable iff (!rstN)
    (ciDone && $past(ciDone)) |-> ($past(ciStart, 3) && $past(ciStart, 4)))
    else $error("ciDone high on consecutive cycles without consecutive starts");

  quietResult: assert property (@(posedge systemClock) disable iff (!rstN)
    !ciDone |-> (ciResult == '0))
    else $error("ciResult nonzero while ciDone is low");

  doneLatency: assert property (@(posedge systemClock) disable iff (!rstN)
    ciDone |-> $past(ciStart, 3))
    else $error("ciDone without a start three cycles earlier");

  // Outputs held low in reset
  resetQuiet: assert property (@(posedge systemClock)
    !rstN |-> (!ciDone && ciResult == '0))
    else $error("ciDone or ciResult active during reset");

endmodule

// File: design/customInstrUnit.sv
`timescale 1ns/10ps

module customInstrUnit (
  input  logic          systemClock,
  input  logic          rstN,
  input  logic          ciStart,
  input  ciPkg::ciIdT   ciN,
  input  ciPkg::ciDataT ciDataA,
  input  ciPkg::ciDataT ciDataB,
  input  logic          stall,
  input  logic          busIdle,
  output logic          ciDone,
  output ciPkg::ciDataT ciResult
);

  logic          execValid;
  ciPkg::ciDataT execValue;
  logic          profValid;
  ciPkg::ciDataT profValue;

  ciIssueIf issueBus ();

  ciDecode decode (
    .systemClock (systemClock),
    .rstN        (rstN),
    .ciStart     (ciStart),
    .ciN         (ciN),
    .ciDataA     (ciDataA),
    .ciDataB     (ciDataB),
    .issue       (issueBus.issuer)
  );

  ciExecute execute (
    .systemClock (systemClock),
    .rstN        (rstN),
    .issue       (issueBus.receiver),
    .execValid   (execValid),
    .execValue   (execValue)
  );

  // Sits beside execute on the same issue
  profileCounters profiler (
    .systemClock (systemClock),
    .rstN        (rstN),
    .stall       (stall),
    .busIdle     (busIdle),
    .issue       (issueBus.receiver),
    .profValid   (profValid),
    .profValue   (profValue)
  );

  ciResult result (
    .systemClock (systemClock),
    .rstN        (rstN),
    .execValid   (execValid),
    .execValue   (execValue),
    .profValid   (profValid),
    .profValue   (profValue),
    .ciDone      (ciDone),
    .ciResult    (ciResult)
  );

endmodule

// File: design/ciResult.sv
`timescale 1ns/10ps

module ciResult (
  input  logic          systemClock,
  input  logic          rstN,
  input  logic          execValid,
  input  ciPkg::ciDataT execValue,
  input  logic          profValid,
  input  ciPkg::ciDataT profValue,
  output logic          ciDone,
  output ciPkg::ciDataT ciResult
);

  ciPkg::ciDataT nextResult;

  // At most one source is valid per cycle
  always_comb begin
    if (execValid) begin
      nextResult = execValue;
    end else if (profValid) begin
      nextResult = profValue;
    end else begin
      nextResult = '0; // Keeps the shared result bus quiet
    end
  end

  always_ff @(posedge systemClock or negedge rstN) begin
    if (!rstN) begin
      ciDone   <= 1'b0;
      ciResult <= '0;
    end else begin
      ciDone   <= execValid | profValid;
      ciResult <= nextResult;
    end
  end

endmodule

// File: design/profileCounters.sv
`timescale 1ns/10ps
`include "customInstr_settings.svh"

module profileCounters (
  input  logic          systemClock,
  input  logic          rstN,
  input  logic          stall,
  input  logic          busIdle,
  ciIssueIf.receiver    issue,
  output logic          profValid,
  output ciPkg::ciDataT profValue
);

  ciPkg::ciDataT                counters [`PROFILE_COUNTERS];
  logic [`PROFILE_COUNTERS-1:0] enables;
  logic [`PROFILE_COUNTERS-1:0] countNow;
  logic [`PROFILE_COUNTERS-1:0] clearNow;
  ciPkg::profileSelT            readSel;
  logic                         profileIssue;

  assign profileIssue = issue.valid && (issue.op == ciPkg::opProfile);
  assign readSel      = issue.dataA[1:0];

  assign countNow = enables & {busIdle, stall, 1'b1}; // Bit order follows counter index
  assign clearNow = profileIssue ?
                    issue.dataB[2*`PROFILE_COUNTERS-1:`PROFILE_COUNTERS] : '0;

  always_ff @(posedge systemClock or negedge rstN) begin
    if (!rstN) begin
      enables <= '0;
      for (int i = 0; i < `PROFILE_COUNTERS; i++) begin
        counters[i] <= '0;
      end
    end else begin
      if (profileIssue) enables <= issue.dataB[`PROFILE_COUNTERS-1:0];
      // Clear wins over counting on the same edge
      for (int i = 0; i < `PROFILE_COUNTERS; i++) begin
        if (clearNow[i]) counters[i] <= '0;
        else if (countNow[i]) counters[i] <= counters[i] + 1'b1;
      end
    end
  end

  always_ff @(posedge systemClock or negedge rstN) begin
    if (!rstN) begin
      profValid <= 1'b0;
    end else begin
      profValid <= profileIssue;
    end
  end

  // Value as it stood before this edge
  always_ff @(posedge systemClock) begin
    if (profileIssue) begin
      profValue <= (readSel < `PROFILE_COUNTERS) ? counters[readSel] : '0;
    end
  end

endmodule

// File: design/ciExecute.sv
`timescale 1ns/10ps
`include "customInstr_settings.svh"

module ciExecute (
  input  logic          systemClock,
  input  logic          rstN,
  ciIssueIf.receiver    issue,
  output logic          execValid,
  output ciPkg::ciDataT execValue
);

  ciPkg::ciDataT swapValue;
  ciPkg::ciDataT grayValue;
  logic [7:0]    red8;
  logic [7:0]    green8;
  logic [7:0]    blue8;
  logic [15:0]   graySum;

  // Full reversal or swap inside each halfword
  always_comb begin
    if (!issue.dataB[0]) begin
      swapValue = {issue.dataA[7:0], issue.dataA[15:8],
                   issue.dataA[23:16], issue.dataA[31:24]};
    end else begin
      swapValue = {issue.dataA[23:16], issue.dataA[31:24],
                   issue.dataA[7:0], issue.dataA[15:8]};
    end
  end

  // RGB565 channels widened to 8 bits by repeating their top bits
  assign red8   = {issue.dataA[15:11], issue.dataA[15:13]};
  assign green8 = {issue.dataA[10:5], issue.dataA[10:9]};
  assign blue8  = {issue.dataA[4:0], issue.dataA[4:2]};

  // Weights sum to 256 so the total fits in 16 bits
  assign graySum = 16'(red8 * `GRAY_WEIGHT_RED +
                       green8 * `GRAY_WEIGHT_GREEN +
                       blue8 * `GRAY_WEIGHT_BLUE);

  assign grayValue = ciPkg::ciDataT'(graySum[15:8]);

  always_ff @(posedge systemClock or negedge rstN) begin
    if (!rstN) begin
      execValid <= 1'b0;
    end else begin
      execValid <= issue.valid && (issue.op != ciPkg::opProfile);
    end
  end

  always_ff @(posedge systemClock) begin
    if (issue.valid) begin
      execValue <= (issue.op == ciPkg::opGray) ? grayValue : swapValue;
    end
  end

endmodule

// File: design/ciDecode.sv
`timescale 1ns/10ps
`include "customInstr_settings.svh"

module ciDecode (
  input  logic          systemClock,
  input  logic          rstN,
  input  logic          ciStart,
  input  ciPkg::ciIdT   ciN,
  input  ciPkg::ciDataT ciDataA,
  input  ciPkg::ciDataT ciDataB,
  ciIssueIf.issuer      issue
);

  ciPkg::ciOpT decodedOp;
  logic        knownId;

  always_comb begin
    knownId   = 1'b1;
    decodedOp = ciPkg::opSwap;
    case (ciN)
      `CI_SWAP_ID:    decodedOp = ciPkg::opSwap;
      `CI_GRAY_ID:    decodedOp = ciPkg::opGray;
      `CI_PROFILE_ID: decodedOp = ciPkg::opProfile;
      default:        knownId   = 1'b0; // Foreign number is never answered
    endcase
  end

  always_ff @(posedge systemClock or negedge rstN) begin
    if (!rstN) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= ciStart & knownId;
    end
  end

  // Operation and operands ride along with valid
  always_ff @(posedge systemClock) begin
    if (ciStart) begin
      issue.op    <= decodedOp;
      issue.dataA <= ciDataA;
      issue.dataB <= ciDataB;
    end
  end

endmodule

// File: design/ciIssueIf.sv
`timescale 1ns/10ps

// Decoded instruction one cycle after ciStart
interface ciIssueIf;
  logic          valid;
  ciPkg::ciOpT   op;
  ciPkg::ciDataT dataA;
  ciPkg::ciDataT dataB;

  modport issuer (
    output valid,
    output op,
    output dataA,
    output dataB
  );

  modport receiver (
    input valid,
    input op,
    input dataA,
    input dataB
  );
endinterface

// File: design/ciPkg.sv
`include "customInstr_settings.svh"

package ciPkg;

  // Operations that survive decode
  typedef enum logic [1:0] {
    opSwap    = 2'd0,
    opGray    = 2'd1,
    opProfile = 2'd2
  } ciOpT;

  typedef logic [`CI_DATA_WIDTH-1:0] ciDataT;

  typedef logic [`CI_ID_WIDTH-1:0] ciIdT;

  // Counter index 0 is cycles, 1 stall cycles and 2 bus idle cycles
  typedef logic [1:0] profileSelT;

endpackage

// File: design/customInstr_settings.svh
`ifndef CUSTOMINSTR_SETTINGS_SVH
`define CUSTOMINSTR_SETTINGS_SVH

// Custom instruction numbers
`define CI_SWAP_ID     8'd1
`define CI_GRAY_ID     8'd9
`define CI_PROFILE_ID  8'd12

`define CI_DATA_WIDTH  32
`define CI_ID_WIDTH    8

// Luminance weights add up to 256
`define GRAY_WEIGHT_RED    77
`define GRAY_WEIGHT_GREEN  150
`define GRAY_WEIGHT_BLUE   29

`define PROFILE_COUNTERS   3 // Cycles, stall, bus idle

`endif
